//--- compile.f
+incdir+include
source/sens_sync_pkg.sv
source/cmd_deser.sv
source/sync_regs.sv
source/frame_sync_filter.sv
source/late_sync_gen.sv
source/sens_sync_top.sv
tests/sens_sync_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the frame-sync testbench with Verilator and run it.
# Pass or fail is read from the simulation log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module sens_sync_tb \
    -f compile.f \
    -o sens_sync_sim

# a failing run exits non-zero, the log check below decides
./obj_dir/sens_sync_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Everything OK$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation did not pass"
    exit 1
fi

//--- tests/sens_sync_tb.sv
/*
 * Testbench for the sensor frame-sync block.
 * Random frames, line timing, trigger pulses and register commands come
 * from an LFSR with a fixed seed. A cycle model of the sync rules runs
 * beside the DUT, and trig, sof_out and sof_late are compared on every
 * falling edge. The first difference stops the run.
 */
`timescale 1ns/1ps

`include "sens_sync_settings.svh"

module sens_sync_tb
    import sens_sync_pkg::*;
();

    localparam int NUM_FRAMES = 60;    // frames over all phases
    localparam int GAP_MIN    = 100;
    localparam int GAP_MAX    = 300;
    localparam int MARGIN     = 2000;  // reset, commands, tail
    localparam int MAX_CYCLES = NUM_FRAMES * GAP_MAX + MARGIN;
    localparam int MINPER     = `SENS_SYNC_MINPER;

    logic       mclk;
    logic       arst_n;
    logic       en;
    sens_evt_t  sens_evt;
    logic       trigger_mode;
    logic       trig_in;
    logic [7:0] cmd_ad;
    logic       cmd_stb;
    logic       trig;
    logic       sof_out;
    logic       sof_late;

    logic [31:0] lfsr;            // random state
    int          cycles    = 0;
    int          n_sof_out = 0;   // seen on the DUT
    int          n_late    = 0;

    // model state
    sync_cfg_t  m_cfg;            // what the registers should hold
    frame_cnt_t m_skip;           // sofs to swallow before the next slot
    int         m_since;          // cycles since last accepted frame
    logic       m_free;
    logic       m_trig;
    logic       m_overdue;
    logic       m_sof_out;
    logic       m_pending;        // delayed strobe armed
    int         m_seen;           // line starts since acceptance
    line_cnt_t  m_lat_dly;        // delay taken at acceptance
    logic       m_hact_q;
    logic       m_sof_late;

    sens_sync_top dut_i (
        .mclk         (mclk),
        .arst_n       (arst_n),
        .en           (en),
        .sens_evt     (sens_evt),
        .trigger_mode (trigger_mode),
        .trig_in      (trig_in),
        .cmd_ad       (cmd_ad),
        .cmd_stb      (cmd_stb),
        .trig         (trig),
        .sof_out      (sof_out),
        .sof_late     (sof_late)
    );

    initial begin
        mclk = 1'b0;
        forever #5 mclk = ~mclk;  // 100 MHz
    end

    // galois lfsr, one step per bit
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + rand_bits(12) % (hi - lo + 1);
    endfunction

    // matching address, bits outside the mask scrambled
    function automatic logic [15:0] hit_addr(input reg_idx_t idx);
        return `SENS_SYNC_ADDR | 16'(rand_bits(5) << 11) | 16'(idx);
    endfunction

    // one bit inside the mask flipped
    function automatic logic [15:0] miss_addr(input reg_idx_t idx);
        return (`SENS_SYNC_ADDR ^ (16'h0004 << rand_range(0, 8))) | 16'(idx);
    endfunction

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1, "run stopped at time %0t", $time);
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // idle cycles, up to two trigger pulses at random spots
    task automatic idle(input int n, input int ntrig);
        int p1;
        int p2;
        p1 = (ntrig > 0) ? rand_range(0, n / 2 - 1) : -1;
        p2 = (ntrig > 1) ? rand_range(n / 2, n - 1) : -1;
        for (int i = 0; i < n; i++) begin
            trig_in = (i == p1) || (i == p2);
            @(negedge mclk);
        end
        trig_in = 1'b0;
    endtask

    // sof, random lines, eof, then idle up to gap cycles
    task automatic send_frame(input int gap, input int ntrig);
        int len;
        int nlines;
        int used;
        len    = rand_range(2, 5);
        nlines = rand_range(1, (gap - 20) / (len + 2));
        if (nlines > 24) begin
            nlines = 24;
        end
        sens_evt.sof = 1'b1;
        @(negedge mclk);
        sens_evt.sof = 1'b0;
        @(negedge mclk);
        for (int l = 0; l < nlines; l++) begin
            sens_evt.hact = 1'b1;
            repeat (len) @(negedge mclk);
            sens_evt.hact = 1'b0;
            repeat (2) @(negedge mclk);  // line blanking
        end
        sens_evt.eof = 1'b1;
        @(negedge mclk);
        sens_evt.eof = 1'b0;
        used = 3 + nlines * (len + 2);
        idle(gap - used, ntrig);
    endtask

    // nbytes below six leaves a broken command behind
    task automatic send_cmd(input logic [15:0] addr, input cmd_data_t data, input int nbytes);
        logic [47:0] bytes;
        bytes = {data, addr};  // al, ah, d0..d3
        for (int i = 0; i < nbytes; i++) begin
            cmd_stb = (i == 0);
            cmd_ad  = bytes[i*8 +: 8];
            @(negedge mclk);
        end
        cmd_stb = 1'b0;
        cmd_ad  = 8'h00;
    endtask

    task automatic write_reg(input logic [15:0] addr, input cmd_data_t data);
        send_cmd(addr, data, 6);
        idle(4, 0);  // write lands, no frame meanwhile
        if (((addr ^ `SENS_SYNC_ADDR) & `SENS_SYNC_MASK) == 16'h0) begin
            if (addr[1:0] == 2'd2) begin
                m_cfg.sub_frames = data[15:0];
            end else if (addr[1:0] == 2'd3) begin
                m_cfg.line_dly = data[15:0];
            end
        end
    endtask

    // cycle model, state from before each rising edge
    always @(posedge mclk) begin : model
        logic acc;
        logic fire;
        logic line_start;
        if (!arst_n) begin
            m_skip     = '0;
            m_since    = MINPER;  // first frame never held
            m_free     = 1'b1;
            m_trig     = 1'b0;
            m_overdue  = 1'b0;
            m_sof_out  = 1'b0;
            m_pending  = 1'b0;
            m_seen     = 0;
            m_lat_dly  = '0;
            m_hact_q   = 1'b0;
            m_sof_late = 1'b0;
        end else begin
            // delayed strobe first, it looks at the previous sof_out
            line_start = sens_evt.hact && !m_hact_q;
            fire = en && m_pending &&
                   (sens_evt.eof || (line_start && m_seen == int'(m_lat_dly)));
            if (!en) begin
                m_pending = 1'b0;
            end else if (m_sof_out) begin
                m_pending = 1'b1;
                m_seen    = 0;
                m_lat_dly = m_cfg.line_dly;
            end else if (fire) begin
                m_pending = 1'b0;
            end else if (m_pending && line_start) begin
                m_seen++;
            end
            m_sof_late = fire;
            m_hact_q   = sens_evt.hact;

            // frame filter
            if (m_since < MINPER) begin
                m_since++;
            end
            acc = en && sens_evt.sof && (m_skip == '0) && (m_since >= MINPER) &&
                  (m_free || m_trig || m_overdue);
            if (acc || !trigger_mode) begin
                m_overdue = 1'b0;
            end else if (trig_in) begin
                m_overdue = m_trig;  // trigger while previous still waiting
            end
            if (!en || !trigger_mode || sens_evt.sof) begin
                m_trig = 1'b0;
            end else if (trig_in) begin
                m_trig = !m_trig;
            end
            if (!trigger_mode || !en) begin
                m_free = 1'b1;
            end else if (sens_evt.sof) begin
                m_free = 1'b0;
            end
            if (!en || (sens_evt.sof && m_skip == '0)) begin
                m_skip = m_cfg.sub_frames;  // slot closes, new group
            end else if (sens_evt.sof) begin
                m_skip = m_skip - 16'd1;
            end
            if (!en) begin
                m_since = MINPER;
            end else if (acc) begin
                m_since = 0;
            end
            m_sof_out = acc;
        end
    end

    // compare where outputs are settled
    always @(negedge mclk) begin
        if (arst_n) begin
            check_val("trig", 32'(trig), 32'(m_trig));
            check_val("sof_out", 32'(sof_out), 32'(m_sof_out));
            check_val("sof_late", 32'(sof_late), 32'(m_sof_late));
            n_sof_out = n_sof_out + int'(sof_out);
            n_late    = n_late + int'(sof_late);
        end
        cycles++;
        if (cycles > MAX_CYCLES) begin
            stop_run($sformatf("timeout: test sequence still running after %0d cycles", cycles));
        end
    end

    initial begin
        lfsr         = 32'h1a7e;
        arst_n       = 1'b0;
        en           = 1'b1;
        sens_evt     = '0;
        trigger_mode = 1'b0;
        trig_in      = 1'b0;
        cmd_ad       = 8'h00;
        cmd_stb      = 1'b0;
        m_cfg        = '{sub_frames: '0, line_dly: line_cnt_t'(`SENS_SYNC_LATE_DFLT)};
        repeat (10) @(negedge mclk);
        arst_n = 1'b1;
        @(negedge mclk);

        // free running, reset defaults, every frame past the hold
        repeat (8) send_frame(rand_range(MINPER, GAP_MAX), 0);

        // frame merging, foreign writes land after the real one
        send_cmd(hit_addr(2'd2), 32'd7, 3);
        write_reg(hit_addr(2'd2), {16'(rand_bits(16)), 16'(rand_range(1, 3))});
        write_reg(miss_addr(2'd2), 32'd5);
        write_reg(miss_addr(2'd3), 32'd1);
        repeat (12) send_frame(rand_range(GAP_MIN, GAP_MAX), 0);

        // shorter line delay, eof often wins
        write_reg(hit_addr(2'd2), 32'd0);
        write_reg(hit_addr(2'd3), {16'(rand_bits(16)), 16'(rand_range(2, 8))});
        repeat (8) send_frame(rand_range(GAP_MIN, GAP_MAX), 0);

        // frames faster than the minimum period
        repeat (10) send_frame(rand_range(60, 200), 0);

        // triggered mode, 0 to 2 triggers per frame
        trigger_mode = 1'b1;
        repeat (14) send_frame(rand_range(GAP_MIN, GAP_MAX), rand_range(0, 2));
        trigger_mode = 1'b0;

        // disabled, then back to free running
        en = 1'b0;
        repeat (4) send_frame(rand_range(GAP_MIN, GAP_MAX), 0);
        en = 1'b1;
        repeat (4) send_frame(rand_range(MINPER, GAP_MAX), 0);

        repeat (20) @(negedge mclk);
        if (n_sof_out == 0 || n_late == 0) begin
            stop_run("no frame made it through the filter during the whole run");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

//--- source/sens_sync_top.sv
/*
 * Frame-sync block of one sensor channel.
 * Chains the command receiver, the configuration registers, the sof
 * filter and the delayed-sof generator. All logic runs on mclk; every
 * strobe in and out is a single cycle with no back-pressure.
 */
`timescale 1ns/1ps

module sens_sync_top
    import sens_sync_pkg::*;
(
    input  logic       mclk,
    input  logic       arst_n,
    input  logic       en,            // channel enable
    input  sens_evt_t  sens_evt,      // sof, eof, hact from the sensor
    input  logic       trigger_mode,  // 1 triggered, 0 free running
    input  logic       trig_in,       // system trigger pulse
    input  logic [7:0] cmd_ad,        // command bytes
    input  logic       cmd_stb,       // first command byte marker
    output logic       trig,          // trigger level to the sensor
    output logic       sof_out,       // filtered start of frame
    output logic       sof_late       // delayed start of frame
);

    cmd_wr_t   cmd_wr;   // register write
    sync_cfg_t cfg;      // live configuration
    logic      sof_acc;  // accepted frame

    cmd_deser cmd_deser_i (
        .mclk    (mclk),
        .arst_n  (arst_n),
        .cmd_ad  (cmd_ad),
        .cmd_stb (cmd_stb),
        .cmd_wr  (cmd_wr)
    );

    sync_regs sync_regs_i (
        .mclk    (mclk),
        .arst_n  (arst_n),
        .cmd_wr  (cmd_wr),
        .cfg     (cfg)
    );

    frame_sync_filter frame_sync_filter_i (
        .mclk         (mclk),
        .arst_n       (arst_n),
        .en           (en),
        .sens_evt     (sens_evt),
        .trigger_mode (trigger_mode),
        .trig_in      (trig_in),
        .cfg          (cfg),
        .trig         (trig),
        .sof_acc      (sof_acc)
    );

    late_sync_gen late_sync_gen_i (
        .mclk     (mclk),
        .arst_n   (arst_n),
        .en       (en),
        .sens_evt (sens_evt),
        .sof_acc  (sof_acc),
        .cfg      (cfg),
        .sof_late (sof_late)
    );

    assign sof_out = sof_acc;  // accepted strobe goes straight out

endmodule

//--- source/late_sync_gen.sv
/*
 * Delayed start-of-frame generator.
 * After an accepted frame it waits for cfg.line_dly + 1 line starts, or
 * for the end of frame if that comes first, then emits sof_late one
 * cycle after the event. A line start is the rising edge of hact.
 */
`timescale 1ns/1ps

module late_sync_gen
    import sens_sync_pkg::*;
(
    input  logic      mclk,
    input  logic      arst_n,
    input  logic      en,        // low clears pending, output stays low
    input  sens_evt_t sens_evt,  // eof and hact used
    input  logic      sof_acc,   // accepted frame strobe
    input  sync_cfg_t cfg,
    output logic      sof_late   // delayed frame strobe
);

    logic      hact_r;      // hact one cycle back
    logic      line_start;
    logic      pending;     // waiting to emit sof_late
    line_cnt_t lines_left;  // line starts still to pass
    logic      last_line;
    logic      fire;

    assign line_start = sens_evt.hact && !hact_r;
    assign last_line  = (lines_left == '0);
    assign fire       = pending && (sens_evt.eof || (line_start && last_line));

    // hact edge detector
    always_ff @(posedge mclk or negedge arst_n) begin
        if (!arst_n) begin
            hact_r <= 1'b0;
        end else begin
            hact_r <= sens_evt.hact;
        end
    end

    // pending flag and line countdown
    always_ff @(posedge mclk or negedge arst_n) begin
        if (!arst_n) begin
            pending    <= 1'b0;
            lines_left <= '0;
        end else if (!en) begin
            pending    <= 1'b0;
            lines_left <= cfg.line_dly;  // parked at load value
        end else if (sof_acc) begin
            pending    <= 1'b1;          // new frame restarts the wait
            lines_left <= cfg.line_dly;
        end else if (fire) begin
            pending    <= 1'b0;
        end else if (pending && line_start) begin
            lines_left <= lines_left - 1'b1;
        end
    end

    // output strobe
    always_ff @(posedge mclk or negedge arst_n) begin
        if (!arst_n) begin
            sof_late <= 1'b0;
        end else begin
            sof_late <= en && fire;
        end
    end

endmodule

//--- source/frame_sync_filter.sv
/*
 * Start-of-frame filter.
 * Passes a sensor sof as sof_acc when the sub-frame countdown is at zero,
 * the minimum-period hold has run out and the frame is admitted, either
 * freely (free-running mode, or first frame in trigger mode), by trig,
 * or by the overdue flag. Also drives the trigger level to the sensor.
 * sof_acc is registered and follows the sof by one cycle.
 */
`timescale 1ns/1ps

`include "sens_sync_settings.svh"

module frame_sync_filter
    import sens_sync_pkg::*;
(
    input  logic      mclk,
    input  logic      arst_n,
    input  logic      en,            // low holds counters, blocks outputs
    input  sens_evt_t sens_evt,      // only sof used here
    input  logic      trigger_mode,  // 1 triggered, 0 free running
    input  logic      trig_in,       // single-cycle system trigger
    input  sync_cfg_t cfg,
    output logic      trig,          // level to the sensor
    output logic      sof_acc        // accepted start of frame
);

    localparam int MB = `SENS_SYNC_MINBITS;
    localparam logic [MB-1:0] HOLD_LOAD = MB'(`SENS_SYNC_MINPER - 1);  // sof cycle counts too

    frame_cnt_t    frames_left;  // sofs still to swallow
    logic [MB-1:0] period_cnt;   // min-period countdown
    logic          zero_left;
    logic          period_hold;
    logic          free_adm;     // admit without trigger
    logic          overdue;      // trigger came while trig already high
    logic          sof_pre;      // accept decision for this sof

    assign zero_left   = (frames_left == '0);
    assign period_hold = (period_cnt != '0);
    assign sof_pre     = en && sens_evt.sof && zero_left && !period_hold &&
                         (free_adm || trig || overdue);

    // sub-frame countdown, linescan merging
    always_ff @(posedge mclk or negedge arst_n) begin
        if (!arst_n) begin
            frames_left <= '0;
        end else if (!en || (sens_evt.sof && zero_left)) begin
            frames_left <= cfg.sub_frames;  // reload, hold while disabled
        end else if (sens_evt.sof) begin
            frames_left <= frames_left - 1'b1;
        end
    end

    // free admission, first sof in trigger mode uses it up
    always_ff @(posedge mclk or negedge arst_n) begin
        if (!arst_n) begin
            free_adm <= 1'b1;
        end else if (!trigger_mode || !en) begin
            free_adm <= 1'b1;
        end else if (sens_evt.sof) begin
            free_adm <= 1'b0;
        end
    end

    // trigger level, toggles per trig_in, dropped at sof
    always_ff @(posedge mclk or negedge arst_n) begin
        if (!arst_n) begin
            trig <= 1'b0;
        end else if (!en || !trigger_mode || sens_evt.sof) begin
            trig <= 1'b0;
        end else if (trig_in) begin
            trig <= ~trig;
        end
    end

    // overdue bypass, long exposure would otherwise halve the rate for good
    always_ff @(posedge mclk or negedge arst_n) begin
        if (!arst_n) begin
            overdue <= 1'b0;
        end else if (sof_pre || !trigger_mode) begin
            overdue <= 1'b0;
        end else if (trig_in) begin
            overdue <= trig;  // second trigger before a frame
        end
    end

    // minimum frame period
    always_ff @(posedge mclk or negedge arst_n) begin
        if (!arst_n) begin
            period_cnt <= '0;
        end else if (!en) begin
            period_cnt <= '0;
        end else if (sof_pre) begin
            period_cnt <= HOLD_LOAD;
        end else if (period_hold) begin
            period_cnt <= period_cnt - 1'b1;
        end
    end

    always_ff @(posedge mclk or negedge arst_n) begin
        if (!arst_n) begin
            sof_acc <= 1'b0;
        end else begin
            sof_acc <= sof_pre;
        end
    end

endmodule

//--- source/sync_regs.sv
/*
 * Configuration registers of the frame-sync block.
 * Takes register writes from the command receiver and keeps the
 * sub-frame count (index 2) and the late-sync line delay (index 3).
 * Writes to indices 0 and 1 are accepted on the bus and have no effect.
 * The new value is visible the cycle after the write strobe.
 */
`timescale 1ns/1ps

`include "sens_sync_settings.svh"

module sync_regs
    import sens_sync_pkg::*;
(
    input  logic      mclk,
    input  logic      arst_n,
    input  cmd_wr_t   cmd_wr,  // write strobe, index, data
    output sync_cfg_t cfg      // current settings
);

    localparam frame_cnt_t SUB_DFLT  = '0;  // every frame passes
    localparam line_cnt_t  LATE_DFLT = line_cnt_t'(`SENS_SYNC_LATE_DFLT);

    logic wr_mult;  // write to sub-frame register
    logic wr_late;  // write to line delay register

    assign wr_mult = cmd_wr.valid && (cmd_wr.idx == `SENS_SYNC_IDX_MULT);
    assign wr_late = cmd_wr.valid && (cmd_wr.idx == `SENS_SYNC_IDX_LATE);

    // sub-frame count, low data bits only
    always_ff @(posedge mclk or negedge arst_n) begin
        if (!arst_n) begin
            cfg.sub_frames <= SUB_DFLT;
        end else if (wr_mult) begin
            cfg.sub_frames <= cmd_wr.data[`SENS_SYNC_FBITS-1:0];
        end
    end

    // line delay for sof_late
    always_ff @(posedge mclk or negedge arst_n) begin
        if (!arst_n) begin
            cfg.line_dly <= LATE_DFLT;
        end else if (wr_late) begin
            cfg.line_dly <= cmd_wr.data[`SENS_SYNC_LBITS-1:0];
        end
    end

endmodule

//--- source/cmd_deser.sv
/*
 * Byte-serial command receiver.
 * cmd_stb marks the address-low byte; five more bytes follow on the next
 * cycles without a strobe. After the sixth byte the address is checked
 * against the base and mask and a one-cycle register write is issued,
 * carrying the two low address bits as index and the 32-bit data.
 */
`timescale 1ns/1ps

`include "sens_sync_settings.svh"

module cmd_deser
    import sens_sync_pkg::*;
(
    input  logic       mclk,
    input  logic       arst_n,
    input  logic [7:0] cmd_ad,   // address/data byte
    input  logic       cmd_stb,  // high with the first byte only
    output cmd_wr_t    cmd_wr    // one write per matching command
);

    localparam int NB  = `SENS_SYNC_NUM_BYTES;
    localparam int SRW = NB * 8;          // whole command in bits
    localparam int CW  = $clog2(NB);      // byte counter width

    logic [CW-1:0]  byte_cnt;   // 0 idle, else index of next byte
    logic [SRW-1:0] sr;         // assembled command, byte 0 lowest
    logic [SRW-1:0] sr_nxt;
    logic [15:0]    addr_nxt;   // address as it will be after this byte
    logic           collecting;
    logic           last_byte;
    logic           addr_hit;
    logic           wr_vld;

    assign collecting = cmd_stb || (byte_cnt != '0);
    assign sr_nxt     = {cmd_ad, sr[SRW-1:8]};  // new byte enters at top
    assign addr_nxt   = sr_nxt[15:0];
    assign addr_hit   = (addr_nxt & `SENS_SYNC_MASK) == (`SENS_SYNC_ADDR & `SENS_SYNC_MASK);
    assign last_byte  = !cmd_stb && (byte_cnt == CW'(NB - 1));  // restart wins

    // byte counter, restarts on every strobe
    always_ff @(posedge mclk or negedge arst_n) begin
        if (!arst_n) begin
            byte_cnt <= '0;
        end else if (cmd_stb) begin
            byte_cnt <= CW'(1);  // byte 0 taken now
        end else if (last_byte) begin
            byte_cnt <= '0;      // command complete
        end else if (byte_cnt != '0) begin
            byte_cnt <= byte_cnt + 1'b1;
        end
    end

    // write strobe, one cycle after the last byte
    always_ff @(posedge mclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_vld <= 1'b0;
        end else begin
            wr_vld <= last_byte && addr_hit;  // foreign addresses dropped
        end
    end

    // shift register, only moves while a command is coming in
    always_ff @(posedge mclk) begin
        if (collecting) begin
            sr <= sr_nxt;
        end
    end

    // held steady while wr_vld is up
    assign cmd_wr = '{valid: wr_vld,
                      idx:   reg_idx_t'(sr[1:0]),
                      data:  cmd_data_t'(sr[SRW-1:16])};

endmodule

//--- source/sens_sync_pkg.sv
/*
 * Shared types for the sensor frame-sync pipeline.
 * Vector typedefs give the counter and command widths a name, the
 * packed structs bundle a register write, the live configuration and
 * the raw sensor events. Stages pick these up by wildcard import.
 */
package sens_sync_pkg;

`include "sens_sync_settings.svh"

    // plain vectors with a meaning
    typedef logic [`SENS_SYNC_FBITS-1:0] frame_cnt_t;  // sub-frame count
    typedef logic [`SENS_SYNC_LBITS-1:0] line_cnt_t;   // line count
    typedef logic [1:0]                  reg_idx_t;    // register select
    typedef logic [31:0]                 cmd_data_t;   // command payload

    // one register write out of the deserializer
    typedef struct packed {
        logic      valid;  // single-cycle write strobe
        reg_idx_t  idx;    // low address bits
        cmd_data_t data;   // d3..d0
    } cmd_wr_t;

    // live configuration seen by filter and late stage
    typedef struct packed {
        frame_cnt_t sub_frames;  // frames to merge minus one
        line_cnt_t  line_dly;    // line starts before sof_late
    } sync_cfg_t;

    // sensor event pulses, all single cycle except hact
    typedef struct packed {
        logic sof;   // start of frame
        logic eof;   // end of frame
        logic hact;  // line active level
    } sens_evt_t;

endpackage

//--- include/sens_sync_settings.svh
/*
 * Build-time settings for the sensor frame-sync block.
 * Holds the command address decode, the command length, the counter
 * widths and the reset defaults. Pulled in by the package and by every
 * stage that needs a constant; the guard keeps repeated includes harmless.
 */
`ifndef SENS_SYNC_SETTINGS_SVH
`define SENS_SYNC_SETTINGS_SVH

// command decode
`define SENS_SYNC_ADDR       16'h0404  // base address of the register group
`define SENS_SYNC_MASK       16'h07fc  // two low bits pick one of four registers
`define SENS_SYNC_NUM_BYTES  6         // al, ah, d0..d3

// register indices inside the group, 0 and 1 unused
`define SENS_SYNC_IDX_MULT   2'd2      // frames to combine, minus one
`define SENS_SYNC_IDX_LATE   2'd3      // line starts before delayed sof

// counter widths
`define SENS_SYNC_FBITS      16        // sub-frame counter
`define SENS_SYNC_LBITS      16        // line counter for sof_late

// defaults and limits
`define SENS_SYNC_LATE_DFLT  15        // line delay after reset
`define SENS_SYNC_MINBITS    8         // minimum-period counter width
`define SENS_SYNC_MINPER     130       // min cycles between accepted frames

`endif
